// File: char_video_pkg.sv
// char video package: raster geometry, ram address widths and tile/pixel field layout
package char_video_pkg;

    // raster, counted in pixels and lines
    localparam int h_total  = 384;  // pixels per line incl. blanking
    localparam int v_total  = 264;  // lines per frame incl. blanking
    localparam int h_active = 320;  // visible pixels
    localparam int v_active = 224;  // visible lines

    // system clocks per pixel enable
    localparam int pxl_div  = 4;

    // tile map: 64 columns x 32 rows of 16-bit words
    localparam int tile_aw  = 11;

    // palette: 128 words, xbgr 555 in the low 15 bits
    localparam int pal_aw   = 7;

    // pixel word going into the palette stage
    // bit 6 priority, bits 5..3 palette, bits 2..0 colour
    localparam int pxl_w    = 7;

    // tile word layout
    // 15..12 unused
    // 11..8  attribute (priority + palette)
    //  7..0  glyph code
    localparam int code_msb = 7;
    localparam int attr_lsb = 8;

    // glyph address into graphics memory
    // {code[8:0], row[2:0], 1'b0}
    // one 32-bit word per glyph row, planes in bytes 2..0
    localparam int gfx_aw   = 13;

endpackage

// File: video_timing.sv
// video timing: pixel enable divider, raster counters and blanking levels
`timescale 1ns/10ps

module video_timing (
    input  logic       clk,
    input  logic       rst,
    output logic       pxl_cen,  // one clock in pxl_div
    output logic [8:0] hdump,    // horizontal position
    output logic [8:0] vdump,    // vertical position
    output logic       lhbl,     // low during horizontal blanking
    output logic       lvbl      // low during vertical blanking
);

    logic [$clog2(char_video_pkg::pxl_div)-1:0] cen_cnt;
    logic                                        h_last;
    logic                                        v_last;

    // pixel enable on the last count of the divider
    assign pxl_cen = cen_cnt == ($bits(cen_cnt))'(char_video_pkg::pxl_div - 1);

    assign h_last = hdump == 9'(char_video_pkg::h_total - 1);
    assign v_last = vdump == 9'(char_video_pkg::v_total - 1);

    // divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
        end else begin
            if (pxl_cen) begin
                cen_cnt <= '0;
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
            end
        end
    end

    // horizontal counter, steps once per pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= 9'd0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hdump <= 9'd0;    // wrap at end of line
            end else begin
                hdump <= hdump + 9'd1;
            end
        end
    end

    // vertical counter, steps when the line wraps
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vdump <= 9'd0;
        end else if (pxl_cen && h_last) begin
            if (v_last) begin
                vdump <= 9'd0;    // new frame
            end else begin
                vdump <= vdump + 9'd1;
            end
        end
    end

    // blanking straight from the counters, so both levels
    // describe the pixel currently on hdump/vdump
    assign lhbl = hdump < 9'(char_video_pkg::h_active);
    assign lvbl = vdump < 9'(char_video_pkg::v_active);

endmodule

// File: dual_port_ram.sv
// dual-port ram: cpu port with byte-lane writes, read-only video port
`timescale 1ns/10ps

module dual_port_ram #(
    parameter int aw = 10
) (
    input  logic          clk,

    // cpu side
    input  logic [aw-1:0] addr0,
    input  logic [15:0]   data0,
    input  logic [ 1:0]   we0,   // bit 1 upper byte, bit 0 lower byte
    output logic [15:0]   q0,

    // video side
    input  logic [aw-1:0] addr1,
    output logic [15:0]   q1
);

    logic [15:0] mem [0:(2**aw)-1];

    // cpu port, read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (we0[0]) begin
            mem[addr0][ 7:0] <= data0[ 7:0];   // low lane
        end
        if (we0[1]) begin
            mem[addr0][15:8] <= data0[15:8];   // high lane
        end
        q0 <= mem[addr0];
    end

    // video port, registered read
    always_ff @(posedge clk) begin
        q1 <= mem[addr1];
    end

endmodule

// File: char_layer.sv
// character layer: tile map scan, glyph fetch address and three-plane pixel shifter
`timescale 1ns/10ps

module char_layer (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     pxl_cen,

    // raster position
    input  logic [8:0]                               hdump,
    input  logic [8:0]                               vdump,

    // tile map video port
    output logic [char_video_pkg::tile_aw-1:0]       tile_scan_addr,
    input  logic [15:0]                              tile_scan,

    // graphics memory
    input  logic                                     char_ok,
    output logic [char_video_pkg::gfx_aw-1:0]        char_addr,
    input  logic [31:0]                              char_data,

    output logic [char_video_pkg::pxl_w-1:0]         pxl
);

    logic [9:0]  h_lead;      // hdump plus two tiles, unwrapped
    logic        lead_wrap;   // lead crosses into the next line
    logic [8:0]  h_ahead;
    logic [8:0]  v_ahead;
    logic        boundary;    // last pixel of a tile
    logic [8:0]  code;
    logic [2:0]  row;         // glyph row for the latched code
    logic [3:0]  attr0;       // attribute of the tile being fetched
    logic [3:0]  attr;        // attribute of the tile on screen
    logic [23:0] pxl_data;    // three planes, msb leftmost

    // position two tiles ahead, wrapped onto the next line
    // so column 0 of each line gets the right row
    assign h_lead    = {1'b0, hdump} + 10'd16;
    assign lead_wrap = h_lead >= 10'(char_video_pkg::h_total);
    assign h_ahead   = lead_wrap ? 9'(h_lead - 10'(char_video_pkg::h_total)) : h_lead[8:0];

    always_comb begin
        v_ahead = vdump;
        if (lead_wrap) begin
            if (vdump == 9'(char_video_pkg::v_total - 1)) begin
                v_ahead = 9'd0;     // lead runs into the next frame
            end else begin
                v_ahead = vdump + 9'd1;
            end
        end
    end

    // 32 rows x 64 columns
    assign tile_scan_addr = {v_ahead[7:3], h_ahead[8:3]};

    assign boundary = hdump[2:0] == 3'd7;

    // one word per glyph row, even addresses only
    assign char_addr = {code, row, 1'b0};

    assign pxl = {attr, pxl_data[23], pxl_data[15], pxl_data[7]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            code     <= 9'd0;
            row      <= 3'd0;
            attr0    <= 4'd0;
            attr     <= 4'd0;
            pxl_data <= 24'd0;
        end else if (pxl_cen) begin
            if (boundary) begin
                // next fetch: tile two columns ahead
                code  <= {1'b0, tile_scan[char_video_pkg::code_msb:0]};
                row   <= v_ahead[2:0];
                attr0 <= tile_scan[char_video_pkg::attr_lsb +: 4];
                attr  <= attr0;           // follows the glyph into the shifter
                // glyph fetched for the previous code, blank if not ready
                pxl_data <= char_ok ? char_data[23:0] : 24'd0;
            end else begin
                pxl_data[23:16] <= {pxl_data[22:16], 1'b0};
                pxl_data[15: 8] <= {pxl_data[14: 8], 1'b0};
                pxl_data[ 7: 0] <= {pxl_data[ 6: 0], 1'b0};
            end
        end
    end

endmodule

// File: palette_lookup.sv
// palette lookup: pixel to 15-bit rgb through palette ram, blanked and registered per pixel
`timescale 1ns/10ps

module palette_lookup (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 pxl_cen,

    // pixel and blanking for the current raster position
    input  logic [char_video_pkg::pxl_w-1:0]     pxl,
    input  logic                                 lhbl,
    input  logic                                 lvbl,

    // palette ram video port
    output logic [char_video_pkg::pal_aw-1:0]    pal_scan_addr,
    input  logic [15:0]                          pal_scan,

    output logic [14:0]                          rgb
);

    logic active;   // pixel is inside the visible area

    // priority bit picks the upper half of the palette
    assign pal_scan_addr = pxl;

    assign active = lhbl & lvbl;

    // pal_scan has settled since pxl changed a full pixel ago
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb <= 15'd0;
        end else if (pxl_cen) begin
            if (active) begin
                rgb <= pal_scan[14:0];   // bit 15 unused
            end else begin
                rgb <= 15'd0;            // black during blanking
            end
        end
    end

endmodule

// File: char_video_top.sv
// character video top: cpu access to tile map and palette, raster timing, char layer and palette
`timescale 1ns/10ps

module char_video_top (
    input  logic                                 clk,
    input  logic                                 rst,

    // cpu bus
    input  logic [12:1]                          cpu_addr,
    input  logic [15:0]                          cpu_dout,
    input  logic [ 1:0]                          dsn,       // active low byte strobes
    input  logic                                 tile_cs,
    input  logic                                 pal_cs,
    output logic [15:0]                          cpu_din,

    // graphics memory
    input  logic                                 char_ok,
    output logic [char_video_pkg::gfx_aw-1:0]    char_addr,
    input  logic [31:0]                          char_data,

    // video out
    output logic [14:0]                          rgb,
    output logic [ 8:0]                          hdump,
    output logic [ 8:0]                          vdump,
    output logic                                 lhbl,
    output logic                                 lvbl,
    output logic                                 pxl_cen
);

    logic [ 1:0]                              tile_we;
    logic [ 1:0]                              pal_we;
    logic [15:0]                              tile_q;
    logic [15:0]                              pal_q;
    logic                                     tile_rd;   // tile map read last clock
    logic                                     pal_rd;    // palette read last clock
    logic [char_video_pkg::tile_aw-1:0]       tile_scan_addr;
    logic [15:0]                              tile_scan;
    logic [char_video_pkg::pal_aw-1:0]        pal_scan_addr;
    logic [15:0]                              pal_scan;
    logic [char_video_pkg::pxl_w-1:0]         pxl;

    // byte lane enables per ram
    assign tile_we = ~dsn & {2{tile_cs}};
    assign pal_we  = ~dsn & {2{pal_cs}};

    // remember which ram was selected, data comes back a clock later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_rd <= 1'b0;
            pal_rd  <= 1'b0;
        end else begin
            tile_rd <= tile_cs;
            pal_rd  <= pal_cs;
        end
    end

    always_comb begin
        cpu_din = 16'd0;            // nothing selected
        if (tile_rd) begin
            cpu_din = tile_q;
        end else if (pal_rd) begin
            cpu_din = pal_q;
        end
    end

    video_timing u_timing (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .pxl_cen ( pxl_cen ),
        .hdump   ( hdump   ),
        .vdump   ( vdump   ),
        .lhbl    ( lhbl    ),
        .lvbl    ( lvbl    )
    );

    dual_port_ram #(.aw(char_video_pkg::tile_aw)) u_tile_ram (
        .clk   ( clk                                   ),
        .addr0 ( cpu_addr[char_video_pkg::tile_aw:1]   ),
        .data0 ( cpu_dout                              ),
        .we0   ( tile_we                               ),
        .q0    ( tile_q                                ),
        .addr1 ( tile_scan_addr                        ),
        .q1    ( tile_scan                             )
    );

    dual_port_ram #(.aw(char_video_pkg::pal_aw)) u_pal_ram (
        .clk   ( clk                                   ),
        .addr0 ( cpu_addr[char_video_pkg::pal_aw:1]    ),
        .data0 ( cpu_dout                              ),
        .we0   ( pal_we                                ),
        .q0    ( pal_q                                 ),
        .addr1 ( pal_scan_addr                         ),
        .q1    ( pal_scan                              )
    );

    char_layer u_char (
        .clk            ( clk            ),
        .rst            ( rst            ),
        .pxl_cen        ( pxl_cen        ),
        .hdump          ( hdump          ),
        .vdump          ( vdump          ),
        .tile_scan_addr ( tile_scan_addr ),
        .tile_scan      ( tile_scan      ),
        .char_ok        ( char_ok        ),
        .char_addr      ( char_addr      ),
        .char_data      ( char_data      ),
        .pxl            ( pxl            )
    );

    palette_lookup u_pal (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .pxl_cen       ( pxl_cen       ),
        .pxl           ( pxl           ),
        .lhbl          ( lhbl          ),
        .lvbl          ( lvbl          ),
        .pal_scan_addr ( pal_scan_addr ),
        .pal_scan      ( pal_scan      ),
        .rgb           ( rgb           )
    );

endmodule

// File: tb_char_video.sv
// testbench for the character video top with cpu access, reset state and full-frame pixel checks
`timescale 1ns/10ps

module tb_char_video;

    logic        clk;
    logic        rst;
    logic [12:1] cpu_addr;
    logic [15:0] cpu_dout;
    logic [ 1:0] dsn;
    logic        tile_cs;
    logic        pal_cs;
    logic [15:0] cpu_din;
    logic        char_ok;
    logic [12:0] char_addr;
    logic [31:0] char_data;
    logic [14:0] rgb;
    logic [ 8:0] hdump;
    logic [ 8:0] vdump;
    logic        lhbl;
    logic        lvbl;
    logic        pxl_cen;

    logic [15:0] tile_mem [0:2047];  // tile map as written by the cpu
    logic [15:0] pal_mem  [0:127];
    integer      seed;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          pixel_checks = 0;
    int          cycle_cnt;
    int          cycle_limit;
    string       cur_test;
    logic        checking;           // pixel scoreboard window
    int          prev_h;             // position whose colour rgb shows now
    int          prev_v;
    logic        prev_visible;
    logic [14:0] exp_rgb;

    char_video_top i_char_video_top (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .dsn       ( dsn       ),
        .tile_cs   ( tile_cs   ),
        .pal_cs    ( pal_cs    ),
        .cpu_din   ( cpu_din   ),
        .char_ok   ( char_ok   ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .rgb       ( rgb       ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .pxl_cen   ( pxl_cen   )
    );

    // graphics memory model with zero latency and char_ok held high
    function automatic logic [31:0] glyph_word(input logic [12:0] addr);
        logic [31:0] x;
        x = {19'd0, addr} * 32'h9e37_79b1;
        return x ^ {13'd0, x[31:13]};
    endfunction

    assign char_ok   = 1'b1;
    assign char_data = glyph_word(char_addr);

    // colour of one raster position from the tile map, glyph model and palette
    function automatic logic [14:0] pixel_colour(input int h, input int v);
        logic [15:0] tile;
        logic [31:0] glyph;
        logic [ 6:0] idx;
        int          bit_n;
        if (h >= char_video_pkg::h_active || v >= char_video_pkg::v_active) begin
            return 15'd0;
        end
        tile  = tile_mem[(v / 8) * 64 + h / 8];
        glyph = glyph_word({1'b0, tile[7:0], v[2:0], 1'b0});
        bit_n = 7 - (h % 8);                 // msb is the leftmost pixel
        idx   = {tile[11:8], glyph[16 + bit_n], glyph[8 + bit_n], glyph[bit_n]};
        return pal_mem[idx][14:0];
    endfunction

    function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] data,
                                                input logic [1:0] strobes);
        logic [15:0] word;
        word = old;
        if (!strobes[0]) begin
            word[7:0] = data[7:0];
        end
        if (!strobes[1]) begin
            word[15:8] = data[15:8];
        end
        return word;
    endfunction

    // rgb lags the raster by one pixel
    always_comb begin
        if (hdump == 9'd0) begin
            prev_h = char_video_pkg::h_total - 1;
            prev_v = (vdump == 9'd0) ? char_video_pkg::v_total - 1 : int'(vdump) - 1;
        end else begin
            prev_h = int'(hdump) - 1;
            prev_v = int'(vdump);
        end
        prev_visible = prev_h < char_video_pkg::h_active && prev_v < char_video_pkg::v_active;
    end

    assign exp_rgb = pixel_colour(prev_h, prev_v);

    task automatic value_error(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        errors++;
        $display("[ERROR] %s: %s expected %h, actual %h", cur_test, what, expected, actual);
    endtask

    task automatic plain_error(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    // sampled on the falling edge where inputs and outputs are settled
    reset_idle: assert property (@(negedge clk)
            rst |-> (rgb == 15'd0 && cpu_din == 16'd0 && lhbl && lvbl))
        else plain_error("outputs not idle while reset is held");

    pixel_match: assert property (@(negedge clk) disable iff (rst)
            (checking && pxl_cen && prev_visible) |-> (rgb == exp_rgb))
        else value_error($sformatf("rgb at x=%0d y=%0d", prev_h, prev_v), 32'(exp_rgb), 32'(rgb));

    blank_black: assert property (@(negedge clk) disable iff (rst)
            (pxl_cen && !prev_visible) |-> (rgb == 15'd0))
        else value_error($sformatf("rgb after blank x=%0d y=%0d", prev_h, prev_v), 32'd0,
                         32'(rgb));

    always @(negedge clk) begin
        if (!rst && checking && pxl_cen && prev_visible) begin
            pixel_checks <= pixel_checks + 1;
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;              // 25 MHz
    end

    initial begin
        cycle_cnt   = 0;
        // two frames plus the cpu phase
        cycle_limit = 2 * char_video_pkg::h_total * char_video_pkg::v_total
                      * char_video_pkg::pxl_div + 2 * (2048 + 128) + 100;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: no result after %0d clock cycles", cycle_limit);
        $display("Testbench failed");
        $finish;
    end

    // all cpu tasks start and end 2 ns after a rising edge
    task automatic write_word(input logic tile, input logic [11:0] addr, input logic [15:0] data,
                              input logic [1:0] strobes);
        tile_cs  = tile;
        pal_cs   = !tile;
        cpu_addr = addr;
        cpu_dout = data;
        dsn      = strobes;
        @(posedge clk);
        #2;
        tile_cs  = 1'b0;
        pal_cs   = 1'b0;
        dsn      = 2'b11;
    endtask

    task automatic read_word(input logic tile, input logic [11:0] addr, output logic [15:0] data);
        tile_cs  = tile;
        pal_cs   = !tile;
        cpu_addr = addr;
        dsn      = 2'b11;                    // select without a write strobe
        @(posedge clk);
        #2;
        tile_cs  = 1'b0;
        pal_cs   = 1'b0;
        @(negedge clk);
        data     = cpu_din;                  // one clock after the select
        @(posedge clk);
        #2;
    endtask

    task automatic expect_word(input logic tile, input logic [11:0] addr,
                               input logic [15:0] expected, input string what);
        logic [15:0] got;
        read_word(tile, addr, got);
        assert (got == expected) else value_error(what, 32'(expected), 32'(got));
    endtask

    task automatic lane_writes(input logic tile, input string ram);
        logic [11:0] addr;
        logic [15:0] data;
        logic [15:0] word;
        addr = 12'($random(seed));
        data = 16'($random(seed));
        write_word(tile, addr, data, 2'b00);
        word = data;
        expect_word(tile, addr, word, {ram, " full word"});
        data = 16'($random(seed));
        write_word(tile, addr, data, 2'b10);   // low lane only
        word = merge_lanes(word, data, 2'b10);
        expect_word(tile, addr, word, {ram, " low lane"});
        data = 16'($random(seed));
        write_word(tile, addr, data, 2'b01);   // high lane only
        word = merge_lanes(word, data, 2'b01);
        expect_word(tile, addr, word, {ram, " high lane"});
        @(negedge clk);
        assert (cpu_din == 16'd0)
            else value_error("cpu_din with no select", 32'd0, 32'(cpu_din));
        @(posedge clk);
        #2;
    endtask

    // same cpu address in both rams keeps two separate words
    task automatic alias_check();
        logic [11:0] addr;
        logic [15:0] tile_word;
        addr      = 12'($random(seed));
        tile_word = 16'($random(seed));
        write_word(1'b1, addr, tile_word, 2'b00);
        write_word(1'b0, addr, ~tile_word, 2'b00);
        expect_word(1'b1, addr, tile_word, "tile word beside palette word");
        expect_word(1'b0, addr, ~tile_word, "palette word beside tile word");
    endtask

    task automatic wait_frame_start();
        @(negedge clk);
        while (!(pxl_cen && hdump == 9'(char_video_pkg::h_total - 1)
                 && vdump == 9'(char_video_pkg::v_total - 1))) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;                                  // raster now at 0,0
    endtask

    task automatic full_frame();
        for (int i = 0; i < 2048; i++) begin
            tile_mem[i] = 16'($random(seed));  // unused top bits random too
            if (i == 0) begin
                tile_mem[i][11] = 1'b1;        // top left tile reads the upper palette half
            end
            write_word(1'b1, 12'(i), tile_mem[i], 2'b00);
        end
        for (int i = 0; i < 128; i++) begin
            pal_mem[i] = 16'($random(seed));
            if (i >= 64 && pal_mem[i][14:0] == pal_mem[i - 64][14:0]) begin
                pal_mem[i] = ~pal_mem[i];     // upper half distinct
            end
            write_word(1'b0, 12'(i), pal_mem[i], 2'b00);
        end
        wait_frame_start();
        checking = 1'b1;
        wait_frame_start();
        checking = 1'b0;
        assert (pixel_checks == char_video_pkg::h_active * char_video_pkg::v_active)
            else value_error("visible pixels checked",
                             32'(char_video_pkg::h_active * char_video_pkg::v_active),
                             32'(pixel_checks));
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic close_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    initial begin
        seed         = 25;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        checking     = 1'b0;
        rst          = 1'b1;
        cpu_addr     = '0;
        cpu_dout     = '0;
        dsn          = 2'b11;
        tile_cs      = 1'b0;
        pal_cs       = 1'b0;
        start_test("reset");
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        assert (rgb == 15'd0) else value_error("rgb", 32'd0, 32'(rgb));
        assert (cpu_din == 16'd0) else value_error("cpu_din", 32'd0, 32'(cpu_din));
        assert (hdump == 9'd0 && vdump == 9'd0) else plain_error("counters not zero after reset");
        assert (lhbl && lvbl) else plain_error("blanking active right after reset");
        @(posedge clk);
        #2;
        close_test();
        start_test("tile_rw");
        lane_writes(1'b1, "tile");
        close_test();
        start_test("pal_rw");
        lane_writes(1'b0, "palette");
        alias_check();
        close_test();
        start_test("frame");
        full_frame();
        close_test();
        $display("tests %0d, failed %0d, errors %0d, pixels checked %0d",
                 tests_run, tests_failed, errors, pixel_checks);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: char_video_top.f
char_video_pkg.sv
video_timing.sv
dual_port_ram.sv
char_layer.sv
palette_lookup.sv
char_video_top.sv
tb_char_video.sv

// File: Makefile
# verilator build and run for the character video testbench

VERILATOR ?= verilator
TOP       ?= tb_char_video
FILELIST  ?= char_video_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
